// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --timing --assert --timescale 1ns/1ps
TOP       = blackjack_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
PASS_TEXT = Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# pass or fail comes from the pass line in the simulator output
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
source/blackjack_pkg.sv
source/card_fetch.sv
source/hand_score.sv
source/bankroll.sv
source/game_fsm.sv
source/blackjack_top.sv
tb/card_dealer.sv
tb/blackjack_tb.sv

// ==== source/bankroll.sv ====
`timescale 1ns/1ps
`default_nettype none

module bankroll
    import blackjack_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  bet_t  bet,
    input  logic  bet_place,
    input  logic  settle,
    input  logic  win,
    input  logic  push,
    input  logic  blackjack,
    output coin_t coins,
    output logic  bet_ok
);

    // bet of the round in play
    bet_t       stake;

    // largest payout is 3 x 15, largest sum 127 + 45
    logic [7:0] payout;
    logic [7:0] credit_sum;
    coin_t      credited;

    assign bet_ok = (bet != '0) && ({3'b000, bet} <= coins);

    // ------------------------------
    // payout on settle
    // ------------------------------

    always_comb begin
        if (blackjack) begin
            payout = {4'b0000, stake} * 8'd3;
        end else if (win) begin
            payout = {4'b0000, stake} * 8'd2;
        end else if (push) begin
            payout = {4'b0000, stake};
        end else begin
            payout = 8'd0;
        end
    end

    assign credit_sum = {1'b0, coins} + payout;

    // saturate at the top of the coin range
    assign credited = (credit_sum > {1'b0, COIN_MAX}) ? COIN_MAX : credit_sum[6:0];

    // ------------------------------
    // coin register
    // ------------------------------

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            coins <= COIN_START;
        end else if (bet_place) begin
            // bet_ok rules out an underflow here
            coins <= coins - {3'b000, bet};
        end else if (settle) begin
            coins <= credited;
        end
    end

    always_ff @(posedge clk) begin
        if (bet_place) begin
            stake <= bet;
        end
    end

endmodule

`default_nettype wire

// ==== source/blackjack_pkg.sv ====
`default_nettype none

package blackjack_pkg;

    // ------------------------------
    // payload widths
    // ------------------------------

    // card value 1..10, ace is 1
    typedef logic [3:0] card_t;

    // hand score, hard total can reach the low thirties
    typedef logic [5:0] score_t;

    typedef logic [6:0] coin_t;
    typedef logic [3:0] bet_t;

    // ------------------------------
    // game rules
    // ------------------------------

    localparam score_t BLACKJACK_SCORE = 6'd21;

    // dealer stops drawing at this score
    localparam score_t DEALER_STAND = 6'd17;

    // one ace counts as 11 when the hand stays at or below 21
    localparam score_t ACE_BONUS = 6'd10;

    localparam coin_t COIN_START = 7'd30;

    // credits saturate here
    localparam coin_t COIN_MAX = 7'd127;

    // player, dealer, player, dealer
    localparam logic [2:0] INITIAL_CARDS = 3'd4;

    // ------------------------------
    // round state
    // ------------------------------

    typedef enum logic [2:0] {
        BET,
        DEAL,
        PLAYER,
        DEALER,
        RESULT
    } game_state_t;

endpackage

`default_nettype wire

// ==== source/blackjack_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module blackjack_top
    import blackjack_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   deal,
    input  logic   hit,
    input  logic   stand,
    input  bet_t   bet,
    input  logic   card_ack,
    input  card_t  card_value,
    output logic   card_req,
    output score_t player_score,
    output score_t dealer_score,
    output coin_t  coins,
    output logic   player_turn,
    output logic   round_done,
    output logic   win,
    output logic   lose,
    output logic   push,
    output logic   blackjack
);

    // ------------------------------
    // internal nets
    // ------------------------------

    logic       fetch_start;
    logic       round_clear;
    card_t      card;
    logic       card_valid;
    logic [2:0] deal_count;
    logic       player_load;
    logic       dealer_load;
    logic [2:0] player_count;
    logic       bet_place;
    logic       settle;
    logic       bet_ok;

    card_fetch u_card_fetch (
        .clk         (clk),
        .reset       (reset),
        .fetch_start (fetch_start),
        .round_clear (round_clear),
        .card_ack    (card_ack),
        .card_value  (card_value),
        .card_req    (card_req),
        .card        (card),
        .card_valid  (card_valid),
        .deal_count  (deal_count)
    );

    // both hands share the fetched card, the load strobe picks one
    hand_score player_hand (
        .clk        (clk),
        .reset      (reset),
        .hand_clear (round_clear),
        .load       (player_load),
        .card       (card),
        .score      (player_score),
        .card_count (player_count)
    );

    // dealer card count is not needed for the outcome
    hand_score dealer_hand (
        .clk        (clk),
        .reset      (reset),
        .hand_clear (round_clear),
        .load       (dealer_load),
        .card       (card),
        .score      (dealer_score),
        .card_count ()
    );

    bankroll u_bankroll (
        .clk       (clk),
        .reset     (reset),
        .bet       (bet),
        .bet_place (bet_place),
        .settle    (settle),
        .win       (win),
        .push      (push),
        .blackjack (blackjack),
        .coins     (coins),
        .bet_ok    (bet_ok)
    );

    game_fsm u_game_fsm (
        .clk          (clk),
        .reset        (reset),
        .deal         (deal),
        .hit          (hit),
        .stand        (stand),
        .bet_ok       (bet_ok),
        .card_valid   (card_valid),
        .deal_count   (deal_count),
        .player_score (player_score),
        .dealer_score (dealer_score),
        .player_count (player_count),
        .fetch_start  (fetch_start),
        .round_clear  (round_clear),
        .player_load  (player_load),
        .dealer_load  (dealer_load),
        .bet_place    (bet_place),
        .settle       (settle),
        .player_turn  (player_turn),
        .round_done   (round_done),
        .win          (win),
        .lose         (lose),
        .push         (push),
        .blackjack    (blackjack)
    );

endmodule

`default_nettype wire

// ==== source/card_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module card_fetch
    import blackjack_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       fetch_start,
    input  logic       round_clear,
    input  logic       card_ack,
    input  card_t      card_value,
    output logic       card_req,
    output card_t      card,
    output logic       card_valid,
    output logic [2:0] deal_count
);

    // four-phase master
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQUEST,
        FETCH_RELEASE
    } fetch_state_t;

    fetch_state_t state;

    // request stays up until the first edge that sees ack
    assign card_req = (state == FETCH_REQUEST);

    // ------------------------------
    // handshake sequencing
    // ------------------------------

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= FETCH_IDLE;
            card_valid <= 1'b0;
        end else begin
            card_valid <= 1'b0;
            case (state)
                FETCH_IDLE: begin
                    if (fetch_start) begin
                        state <= FETCH_REQUEST;
                    end
                end
                FETCH_REQUEST: begin
                    if (card_ack) begin
                        state <= FETCH_RELEASE;
                    end
                end
                FETCH_RELEASE: begin
                    // source has released, hand the card over
                    if (!card_ack) begin
                        state      <= FETCH_IDLE;
                        card_valid <= 1'b1;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    // value is stable while ack is high
    always_ff @(posedge clk) begin
        if (state == FETCH_REQUEST && card_ack) begin
            card <= card_value;
        end
    end

    // ------------------------------
    // cards delivered this round
    // ------------------------------

    // holds the index of the card while card_valid is high
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            deal_count <= 3'd0;
        end else if (round_clear) begin
            deal_count <= 3'd0;
        end else if (card_valid) begin
            deal_count <= deal_count + 3'd1;
        end
    end

endmodule

`default_nettype wire

// ==== source/game_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_fsm
    import blackjack_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       deal,
    input  logic       hit,
    input  logic       stand,
    input  logic       bet_ok,
    input  logic       card_valid,
    input  logic [2:0] deal_count,
    input  score_t     player_score,
    input  score_t     dealer_score,
    input  logic [2:0] player_count,
    output logic       fetch_start,
    output logic       round_clear,
    output logic       player_load,
    output logic       dealer_load,
    output logic       bet_place,
    output logic       settle,
    output logic       player_turn,
    output logic       round_done,
    output logic       win,
    output logic       lose,
    output logic       push,
    output logic       blackjack
);

    game_state_t state;

    // a card has been asked for and not yet delivered
    logic pending;

    logic start_round;
    logic last_deal;
    logic player_bust;
    logic dealer_bust;
    logic player_wins;
    logic hands_tie;
    logic natural;

    assign start_round = (state == BET) && deal && bet_ok;
    assign last_deal   = (deal_count == INITIAL_CARDS - 3'd1);

    assign bet_place   = start_round;
    assign round_clear = start_round;

    // waiting on the player, nothing in flight and not yet on 21
    assign player_turn = (state == PLAYER) && !pending && (player_score < BLACKJACK_SCORE);

    // ------------------------------
    // outcome
    // ------------------------------

    assign player_bust = player_score > BLACKJACK_SCORE;
    assign dealer_bust = dealer_score > BLACKJACK_SCORE;
    assign player_wins = !player_bust && (dealer_bust || player_score > dealer_score);
    assign hands_tie   = !player_bust && !dealer_bust && (player_score == dealer_score);
    assign natural     = (player_score == BLACKJACK_SCORE) && (player_count == 3'd2);

    // ------------------------------
    // fetch requests and card routing
    // ------------------------------

    always_comb begin
        fetch_start = 1'b0;
        player_load = 1'b0;
        dealer_load = 1'b0;
        case (state)
            DEAL: begin
                fetch_start = !pending;
                // even index to the player, odd to the dealer
                player_load = card_valid && !deal_count[0];
                dealer_load = card_valid && deal_count[0];
            end
            PLAYER: begin
                fetch_start = player_turn && hit;
                player_load = card_valid;
            end
            DEALER: begin
                fetch_start = !pending && (dealer_score < DEALER_STAND);
                dealer_load = card_valid;
            end
            default: begin
            end
        endcase
    end

    // ------------------------------
    // round sequencing
    // ------------------------------

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= BET;
            pending    <= 1'b0;
            settle     <= 1'b0;
            round_done <= 1'b0;
            win        <= 1'b0;
            lose       <= 1'b0;
            push       <= 1'b0;
            blackjack  <= 1'b0;
        end else begin
            round_done <= 1'b0;
            if (fetch_start) begin
                pending <= 1'b1;
            end else if (card_valid) begin
                pending <= 1'b0;
            end

            case (state)
                BET: begin
                    if (start_round) begin
                        state     <= DEAL;
                        win       <= 1'b0;
                        lose      <= 1'b0;
                        push      <= 1'b0;
                        blackjack <= 1'b0;
                    end
                end
                DEAL: begin
                    if (card_valid && last_deal) begin
                        state <= PLAYER;
                    end
                end
                PLAYER: begin
                    // bust skips the dealer, 21 hands over without input
                    if (!pending && player_bust) begin
                        state <= RESULT;
                    end else if (!pending && player_score == BLACKJACK_SCORE) begin
                        state <= DEALER;
                    end else if (player_turn && !hit && stand) begin
                        state <= DEALER;
                    end
                end
                DEALER: begin
                    if (!pending && dealer_score >= DEALER_STAND) begin
                        state <= RESULT;
                    end
                end
                RESULT: begin
                    // first cycle latches the outcome, second pays out
                    if (!settle) begin
                        settle    <= 1'b1;
                        win       <= player_wins;
                        push      <= hands_tie;
                        lose      <= !player_wins && !hands_tie;
                        blackjack <= player_wins && natural;
                    end else begin
                        settle     <= 1'b0;
                        round_done <= 1'b1;
                        state      <= BET;
                    end
                end
                default: state <= BET;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/hand_score.sv ====
`timescale 1ns/1ps
`default_nettype none

module hand_score
    import blackjack_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       hand_clear,
    input  logic       load,
    input  card_t      card,
    output score_t     score,
    output logic [2:0] card_count
);

    // all aces counted as 1
    score_t hard_total;
    logic   has_ace;
    score_t soft_total;

    // ------------------------------
    // ace adjustment
    // ------------------------------

    // only one ace can ever be promoted without busting
    assign soft_total = hard_total + ACE_BONUS;

    assign score = (has_ace && soft_total <= BLACKJACK_SCORE) ? soft_total : hard_total;

    // ------------------------------
    // running totals
    // ------------------------------

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hard_total <= '0;
            has_ace    <= 1'b0;
            card_count <= 3'd0;
        end else if (hand_clear) begin
            hard_total <= '0;
            has_ace    <= 1'b0;
            card_count <= 3'd0;
        end else if (load) begin
            hard_total <= hard_total + {2'b00, card};
            if (card == 4'd1) begin
                has_ace <= 1'b1;
            end
            // stick at 7 so a long hand never reads as two cards
            if (card_count != 3'd7) begin
                card_count <= card_count + 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/blackjack_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module blackjack_tb
    import blackjack_pkg::*;
();

    localparam int CLOCK_PERIOD  = 40;
    localparam int ROUND_COUNT   = 32;
    localparam int CYCLE_LIMIT   = 2000 * ROUND_COUNT;
    localparam int DECK_DEPTH    = 40;
    localparam int RANDOM_ROUNDS = 20;

    logic       clk;
    logic       reset;
    logic       deal;
    logic       hit;
    logic       stand;
    bet_t       bet;
    logic       card_ack;
    card_t      card_value;
    logic       card_req;
    score_t     player_score;
    score_t     dealer_score;
    coin_t      coins;
    logic       player_turn;
    logic       round_done;
    logic       win;
    logic       lose;
    logic       push;
    logic       blackjack;
    logic       stock;
    card_t      stock_card;
    logic [7:0] cards_left;
    logic       starved;

    // reference model state
    int deck[$];
    bit choices[$];
    bit moves[$];
    int draw_idx;
    int model_coins;
    int exp_player;
    int exp_dealer;
    bit exp_win;
    bit exp_lose;
    bit exp_push;
    bit exp_bj;

    int cycle_count = 0;

    blackjack_top DUT (
        .clk          (clk),
        .reset        (reset),
        .deal         (deal),
        .hit          (hit),
        .stand        (stand),
        .bet          (bet),
        .card_ack     (card_ack),
        .card_value   (card_value),
        .card_req     (card_req),
        .player_score (player_score),
        .dealer_score (dealer_score),
        .coins        (coins),
        .player_turn  (player_turn),
        .round_done   (round_done),
        .win          (win),
        .lose         (lose),
        .push         (push),
        .blackjack    (blackjack)
    );

    card_dealer dealer (
        .clk        (clk),
        .card_req   (card_req),
        .stock      (stock),
        .stock_card (stock_card),
        .card_ack   (card_ack),
        .card_value (card_value),
        .cards_left (cards_left),
        .starved    (starved)
    );

    initial begin
        clk = 1'b0;
        forever #(CLOCK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            stop_on_error($sformatf("timeout after %0d cycles, the rounds did not finish",
                                    cycle_count));
        end
    end

    // ------------------------------
    // protocol and outcome checks
    // ------------------------------

    assert property (@(posedge clk) disable iff (reset) round_done |-> $onehot({win, lose, push}))
        else stop_on_error("round ended without exactly one of win, lose and push");

    assert property (@(posedge clk) disable iff (reset) blackjack |-> win)
        else stop_on_error("blackjack flag is high without a win");

    assert property (@(posedge clk) disable iff (reset) player_turn |-> !card_req)
        else stop_on_error("player turn offered while a card request is open");

    assert property (@(posedge clk) !starved)
        else stop_on_error("the DUT asked for more cards than the round should use");

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string test, input string what,
                               input int expected, input int actual);
        assert (actual == expected)
            else stop_on_error($sformatf("ERROR %s: %s expected %0d actual %0d",
                                         test, what, expected, actual));
    endtask

    // ------------------------------
    // reference model
    // ------------------------------

    // one ace is worth 11 if that keeps the hand at 21 or below
    function automatic int hand_value(input int hard, input bit ace);
        if (ace && hard + int'(ACE_BONUS) <= int'(BLACKJACK_SCORE)) begin
            return hard + int'(ACE_BONUS);
        end
        return hard;
    endfunction

    task automatic draw_card(output int value);
        if (draw_idx >= deck.size()) begin
            stop_on_error("the deck of this test is too short for the round");
        end else begin
            value = deck[draw_idx];
            draw_idx++;
        end
    endtask

    task automatic predict_round(input int bet_coins);
        int n;
        int value;
        int p_hard;
        int d_hard;
        int p_cards;
        int payout;
        bit p_ace;
        bit d_ace;
        bit standing;
        bit hit_now;
        p_hard   = 0;
        d_hard   = 0;
        p_cards  = 0;
        p_ace    = 1'b0;
        d_ace    = 1'b0;
        standing = 1'b0;
        draw_idx = 0;
        moves.delete();
        // opening deal alternates, player first
        for (n = 0; n < int'(INITIAL_CARDS); n++) begin
            draw_card(value);
            if (n % 2 == 0) begin
                p_hard += value;
                p_ace  |= (value == 1);
                p_cards++;
            end else begin
                d_hard += value;
                d_ace  |= (value == 1);
            end
        end
        while (!standing && hand_value(p_hard, p_ace) < int'(BLACKJACK_SCORE)) begin
            hit_now = (moves.size() < choices.size()) ? choices[moves.size()] : 1'b0;
            moves.push_back(hit_now);
            if (hit_now) begin
                draw_card(value);
                p_hard += value;
                p_ace  |= (value == 1);
                p_cards++;
            end else begin
                standing = 1'b1;
            end
        end
        exp_player = hand_value(p_hard, p_ace);
        // a busted player leaves the dealer hand alone
        if (exp_player <= int'(BLACKJACK_SCORE)) begin
            while (hand_value(d_hard, d_ace) < int'(DEALER_STAND)) begin
                draw_card(value);
                d_hard += value;
                d_ace  |= (value == 1);
            end
        end
        exp_dealer = hand_value(d_hard, d_ace);
        exp_win  = (exp_player <= int'(BLACKJACK_SCORE)) &&
                   (exp_dealer > int'(BLACKJACK_SCORE) || exp_player > exp_dealer);
        exp_push = (exp_player <= int'(BLACKJACK_SCORE)) &&
                   (exp_dealer <= int'(BLACKJACK_SCORE)) && (exp_player == exp_dealer);
        exp_lose = !exp_win && !exp_push;
        exp_bj   = exp_win && (exp_player == int'(BLACKJACK_SCORE)) && (p_cards == 2);
        payout = exp_bj ? 3 * bet_coins : exp_win ? 2 * bet_coins : exp_push ? bet_coins : 0;
        model_coins = model_coins - bet_coins + payout;
        if (model_coins > int'(COIN_MAX)) begin
            model_coins = int'(COIN_MAX);
        end
    endtask

    // ------------------------------
    // round driving
    // ------------------------------

    task automatic play_round(input string name, input int bet_coins);
        int k;
        int move_idx;
        bit done;
        predict_round(bet_coins);
        // stock exactly the cards the model uses
        for (k = 0; k < draw_idx; k++) begin
            @(negedge clk);
            stock      = 1'b1;
            stock_card = card_t'(deck[k]);
        end
        @(negedge clk);
        stock = 1'b0;
        bet   = bet_t'(bet_coins);
        deal  = 1'b1;
        @(negedge clk);
        deal     = 1'b0;
        move_idx = 0;
        done     = 1'b0;
        while (!done) begin
            @(negedge clk);
            hit   = 1'b0;
            stand = 1'b0;
            if (round_done) begin
                done = 1'b1;
            end else if (player_turn) begin
                if (move_idx >= moves.size()) begin
                    stop_on_error($sformatf("%s: player was offered one turn too many", name));
                end else begin
                    hit   = moves[move_idx];
                    stand = !moves[move_idx];
                    move_idx++;
                end
            end
        end
        check_value(name, "player_score", exp_player, int'(player_score));
        check_value(name, "dealer_score", exp_dealer, int'(dealer_score));
        check_value(name, "win", int'(exp_win), int'(win));
        check_value(name, "lose", int'(exp_lose), int'(lose));
        check_value(name, "push", int'(exp_push), int'(push));
        check_value(name, "blackjack", int'(exp_bj), int'(blackjack));
        check_value(name, "coins", model_coins, int'(coins));
        check_value(name, "player turns", moves.size(), move_idx);
        check_value(name, "unused cards", 0, int'(cards_left));
    endtask

    task automatic try_rejected_bet(input string name, input int bet_coins);
        int k;
        int coins_before;
        @(negedge clk);
        coins_before = int'(coins);
        bet  = bet_t'(bet_coins);
        deal = 1'b1;
        for (k = 0; k < 20; k++) begin
            @(negedge clk);
            assert (!card_req && !player_turn)
                else stop_on_error($sformatf("%s: a rejected bet started a round", name));
        end
        deal = 1'b0;
        check_value(name, "coins", coins_before, int'(coins));
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------

    initial begin
        int r;
        int top;
        void'($urandom(3575));
        reset       = 1'b1;
        deal        = 1'b0;
        hit         = 1'b0;
        stand       = 1'b0;
        bet         = '0;
        stock       = 1'b0;
        stock_card  = '0;
        model_coins = int'(COIN_START);
        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        check_value("reset values", "coins", int'(COIN_START), int'(coins));
        assert (!card_req && !player_turn && !round_done && !win && !lose && !push && !blackjack)
            else stop_on_error("a handshake, turn or outcome output is high after reset");

        try_rejected_bet("zero bet", 0);

        deck    = '{10, 5, 6, 9, 7};
        choices = '{1'b1};
        play_round("player bust", 15);
        deck    = '{9, 2, 8, 3, 10};
        choices = '{1'b1};
        play_round("second bust", 12);

        // coins are down to 3 here
        try_rejected_bet("bet above coins", 9);

        deck    = '{10, 6, 8, 5, 3, 4};
        choices = '{1'b0};
        play_round("stand and dealer draws", 3);
        deck    = '{10, 2, 8, 4, 1};
        choices = '{1'b0};
        play_round("dealer soft ace", 3);

        deck = '{1, 9, 10, 7, 10};
        choices.delete();
        play_round("blackjack", 6);

        for (r = 0; r < 5; r++) begin
            deck = '{1, 9, 10, 7, 10};
            choices.delete();
            play_round($sformatf("saturation round %0d", r), 15);
        end
        check_value("coin saturation", "coins", int'(COIN_MAX), int'(coins));

        for (r = 0; r < RANDOM_ROUNDS; r++) begin
            deck.delete();
            choices.delete();
            repeat (DECK_DEPTH) begin
                deck.push_back(1 + $urandom % 10);
                choices.push_back(1'($urandom % 2));
            end
            top = (model_coins > 15) ? 15 : model_coins;
            if (top == 0) begin
                continue;
            end
            play_round($sformatf("random round %0d", r), 1 + $urandom % top);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/card_dealer.sv ====
`timescale 1ns/1ps
`default_nettype none

module card_dealer
    import blackjack_pkg::*;
(
    input  logic       clk,
    input  logic       card_req,
    input  logic       stock,
    input  card_t      stock_card,
    output logic       card_ack,
    output card_t      card_value,
    output logic [7:0] cards_left,
    output logic       starved
);

    // cards waiting to be served, oldest first
    card_t shoe[$];
    int    wait_left;
    logic  counting;

    initial begin
        card_ack   = 1'b0;
        card_value = '0;
        cards_left = '0;
        starved    = 1'b0;
        counting   = 1'b0;
        wait_left  = 0;
        forever begin
            // stocking is sampled on the rising edge
            @(posedge clk);
            if (stock) begin
                shoe.push_back(stock_card);
            end
            cards_left = 8'(shoe.size());

            // handshake moves on the falling edge
            @(negedge clk);
            if (card_ack) begin
                // release once the request has dropped
                if (!card_req) begin
                    card_ack = 1'b0;
                end
            end else if (card_req) begin
                if (!counting) begin
                    counting  = 1'b1;
                    wait_left = $urandom % 6;
                end
                if (wait_left != 0) begin
                    wait_left = wait_left - 1;
                end else if (shoe.size() == 0) begin
                    starved = 1'b1;
                end else begin
                    counting   = 1'b0;
                    card_value = shoe.pop_front();
                    card_ack   = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire
